/* common/cpuPkg.sv */
// CPU package with word types, memory sizes, opcodes and control encodings
`default_nettype none

package cpuPkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] regIdx_t;
	typedef logic [4:0] opcode_t;

	localparam int NUM_REGS = 8;
	localparam int IMEM_WORDS = 256;
	localparam int DMEM_WORDS = 256;

	typedef logic [$clog2(IMEM_WORDS)-1:0] imemAddr_t;
	typedef logic [$clog2(DMEM_WORDS)-1:0] dmemAddr_t;

	// Written by jal and jalr
	localparam regIdx_t LINK_REG = 3'd7;

	// Major opcodes, bits 15:11
	localparam opcode_t OP_HALT = 5'b00000;
	localparam opcode_t OP_NOP = 5'b00001;
	localparam opcode_t OP_SIIC = 5'b00010;
	localparam opcode_t OP_RTI = 5'b00011;
	localparam opcode_t OP_ADDI = 5'b01000;
	localparam opcode_t OP_SUBI = 5'b01001;
	localparam opcode_t OP_XORI = 5'b01010;
	localparam opcode_t OP_ANDI = 5'b01011;
	localparam opcode_t OP_BEQZ = 5'b01100;
	localparam opcode_t OP_BNEZ = 5'b01101;
	localparam opcode_t OP_BLTZ = 5'b01110;
	localparam opcode_t OP_BGEZ = 5'b01111;
	localparam opcode_t OP_ST = 5'b10000;
	localparam opcode_t OP_LD = 5'b10001;
	localparam opcode_t OP_SLBI = 5'b10010;
	localparam opcode_t OP_STU = 5'b10011;
	localparam opcode_t OP_ROLI = 5'b10100;
	localparam opcode_t OP_SLLI = 5'b10101;
	localparam opcode_t OP_RORI = 5'b10110;
	localparam opcode_t OP_SRLI = 5'b10111;
	localparam opcode_t OP_LBI = 5'b11000;
	localparam opcode_t OP_BTR = 5'b11001;
	localparam opcode_t OP_SHIFT_RR = 5'b11010;
	localparam opcode_t OP_ALU_RR = 5'b11011;
	localparam opcode_t OP_SEQ = 5'b11100;
	localparam opcode_t OP_SLT = 5'b11101;
	localparam opcode_t OP_SLE = 5'b11110;
	localparam opcode_t OP_SCO = 5'b11111;
	localparam opcode_t OP_J = 5'b00100;
	localparam opcode_t OP_JR = 5'b00101;
	localparam opcode_t OP_JAL = 5'b00110;
	localparam opcode_t OP_JALR = 5'b00111;

	// Low two bits of each group line up with the opcode or function bits
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_XOR = 4'd2,
		ALU_ANDN = 4'd3,
		ALU_ROL = 4'd4,
		ALU_SLL = 4'd5,
		ALU_ROR = 4'd6,
		ALU_SRL = 4'd7,
		ALU_SEQ = 4'd8,
		ALU_SLT = 4'd9,
		ALU_SLE = 4'd10,
		ALU_SCO = 4'd11,
		ALU_BTR = 4'd12,
		ALU_LBI = 4'd13,
		ALU_SLBI = 4'd14,
		ALU_PASSB = 4'd15
	} aluOp_t;

	typedef enum logic [2:0] {
		IMM_S5,
		IMM_Z5,
		IMM_S8,
		IMM_Z8,
		IMM_S11
	} immSel_t;

	typedef enum logic [1:0] {
		DEST_4_2,
		DEST_7_5,
		DEST_10_8,
		DEST_LINK
	} destSel_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC2
	} wbSel_t;

	// Same order as the branch opcode low bits
	typedef enum logic [1:0] {
		BR_EQZ,
		BR_NEZ,
		BR_LTZ,
		BR_GEZ
	} brCond_t;

endpackage

`default_nettype wire

/* decode/instrDecoder.sv */
// Instruction decoder turning the major opcode into control levels
`timescale 1ns/100ps
`default_nettype none

module instrDecoder import cpuPkg::*; (
	input wire word_t instr,
	output aluOp_t aluOp,
	output immSel_t immSel,
	output destSel_t destSel,
	output wbSel_t wbSel,
	output brCond_t brCond,
	output logic aluSrc,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output logic branch,
	output logic jump,
	output logic jumpReg,
	output logic halt
);

	opcode_t opcode;

	assign opcode = instr[15:11];

	always_comb begin
		aluOp = ALU_PASSB;
		immSel = IMM_S5;
		destSel = DEST_4_2;
		wbSel = WB_ALU;
		brCond = BR_EQZ;
		aluSrc = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		halt = 1'b0;

		case (opcode)
			OP_HALT: halt = 1'b1;
			// siic and rti behave as nop here
			OP_NOP, OP_SIIC, OP_RTI: ;
			OP_ADDI, OP_SUBI: begin
				aluOp = aluOp_t'({2'b00, opcode[1:0]});
				aluSrc = 1'b1;
				destSel = DEST_7_5;
				regWrite = 1'b1;
			end
			OP_XORI, OP_ANDI: begin
				aluOp = aluOp_t'({2'b00, opcode[1:0]});
				aluSrc = 1'b1;
				immSel = IMM_Z5;
				destSel = DEST_7_5;
				regWrite = 1'b1;
			end
			OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
				aluOp = aluOp_t'({2'b01, opcode[1:0]});
				aluSrc = 1'b1;
				immSel = IMM_Z5;
				destSel = DEST_7_5;
				regWrite = 1'b1;
			end
			OP_ST: begin
				aluOp = ALU_ADD;
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			OP_LD: begin
				aluOp = ALU_ADD;
				aluSrc = 1'b1;
				memRead = 1'b1;
				wbSel = WB_MEM;
				destSel = DEST_7_5;
				regWrite = 1'b1;
			end
			// Store with base update
			OP_STU: begin
				aluOp = ALU_ADD;
				aluSrc = 1'b1;
				memWrite = 1'b1;
				destSel = DEST_10_8;
				regWrite = 1'b1;
			end
			OP_BTR: begin
				aluOp = ALU_BTR;
				regWrite = 1'b1;
			end
			OP_ALU_RR: begin
				aluOp = aluOp_t'({2'b00, instr[1:0]});
				regWrite = 1'b1;
			end
			OP_SHIFT_RR: begin
				aluOp = aluOp_t'({2'b01, instr[1:0]});
				regWrite = 1'b1;
			end
			OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
				aluOp = aluOp_t'({2'b10, opcode[1:0]});
				regWrite = 1'b1;
			end
			OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
				branch = 1'b1;
				brCond = brCond_t'(opcode[1:0]);
				immSel = IMM_S8;
			end
			OP_LBI: begin
				aluOp = ALU_LBI;
				aluSrc = 1'b1;
				immSel = IMM_S8;
				destSel = DEST_10_8;
				regWrite = 1'b1;
			end
			OP_SLBI: begin
				aluOp = ALU_SLBI;
				aluSrc = 1'b1;
				immSel = IMM_Z8;
				destSel = DEST_10_8;
				regWrite = 1'b1;
			end
			OP_J: begin
				jump = 1'b1;
				immSel = IMM_S11;
			end
			OP_JAL: begin
				jump = 1'b1;
				immSel = IMM_S11;
				destSel = DEST_LINK;
				wbSel = WB_PC2;
				regWrite = 1'b1;
			end
			// Target is Rs plus imm, computed by the ALU
			OP_JR: begin
				jumpReg = 1'b1;
				aluOp = ALU_ADD;
				aluSrc = 1'b1;
				immSel = IMM_S8;
			end
			OP_JALR: begin
				jumpReg = 1'b1;
				aluOp = ALU_ADD;
				aluSrc = 1'b1;
				immSel = IMM_S8;
				destSel = DEST_LINK;
				wbSel = WB_PC2;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* design/regFile.sv */
// Register file with eight words, two combinational reads and one clocked write
`timescale 1ns/100ps
`default_nettype none

module regFile import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire regIdx_t rsIdx,
	input wire regIdx_t rtIdx,
	input wire regIdx_t wrIdx,
	input wire logic wrEn,
	input wire word_t wrData,
	output word_t rsData,
	output word_t rtData
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrIdx] <= wrData;
		end
	end

	// No bypass of a write in the same cycle
	assign rsData = regs[rsIdx];
	assign rtData = regs[rtIdx];

endmodule

`default_nettype wire

/* design/execUnit.sv */
// Execute unit with immediate extension, ALU and write-back selection
`timescale 1ns/100ps
`default_nettype none

module execUnit import cpuPkg::*; (
	input wire word_t instr,
	input wire word_t rsData,
	input wire word_t rtData,
	input wire word_t memData,
	input wire word_t pcPlus2,
	input wire aluOp_t aluOp,
	input wire immSel_t immSel,
	input wire destSel_t destSel,
	input wire wbSel_t wbSel,
	input wire logic aluSrc,
	input wire logic regWrite,
	input wire logic run,
	input wire logic halted,
	output regIdx_t rsIdx,
	output regIdx_t rtIdx,
	output regIdx_t wrIdx,
	output logic wrEn,
	output word_t wrData,
	output word_t aluOut,
	output word_t storeData
);

	word_t immExt;
	word_t opB;
	logic [3:0] shAmt;
	logic [16:0] carrySum;

	assign rsIdx = instr[10:8];
	assign rtIdx = instr[7:5];

	always_comb begin
		case (immSel)
			IMM_S5: immExt = {{11{instr[4]}}, instr[4:0]};
			IMM_Z5: immExt = {11'd0, instr[4:0]};
			IMM_S8: immExt = {{8{instr[7]}}, instr[7:0]};
			IMM_Z8: immExt = {8'd0, instr[7:0]};
			IMM_S11: immExt = {{5{instr[10]}}, instr[10:0]};
			default: immExt = '0;
		endcase
	end

	assign opB = aluSrc ? immExt : rtData;
	assign shAmt = opB[3:0];
	assign carrySum = {1'b0, rsData} + {1'b0, opB};

	always_comb begin
		case (aluOp)
			ALU_ADD: aluOut = rsData + opB;
			ALU_SUB: aluOut = opB - rsData;
			ALU_XOR: aluOut = rsData ^ opB;
			ALU_ANDN: aluOut = rsData & ~opB;
			ALU_ROL: aluOut = (rsData << shAmt) | (rsData >> (5'd16 - {1'b0, shAmt}));
			ALU_SLL: aluOut = rsData << shAmt;
			ALU_ROR: aluOut = (rsData >> shAmt) | (rsData << (5'd16 - {1'b0, shAmt}));
			ALU_SRL: aluOut = rsData >> shAmt;
			ALU_SEQ: aluOut = {15'd0, rsData == opB};
			ALU_SLT: aluOut = {15'd0, $signed(rsData) < $signed(opB)};
			ALU_SLE: aluOut = {15'd0, $signed(rsData) <= $signed(opB)};
			ALU_SCO: aluOut = {15'd0, carrySum[16]};
			ALU_BTR: aluOut = {<<{rsData}};
			ALU_LBI: aluOut = immExt;
			// Upper byte from Rs, lower byte from the zero-extended imm
			ALU_SLBI: aluOut = {rsData[7:0], 8'h00} | opB;
			ALU_PASSB: aluOut = opB;
		endcase
	end

	// Data for st and stu comes from bits 7:5
	assign storeData = rtData;

	always_comb begin
		case (destSel)
			DEST_4_2: wrIdx = instr[4:2];
			DEST_7_5: wrIdx = instr[7:5];
			DEST_10_8: wrIdx = instr[10:8];
			DEST_LINK: wrIdx = LINK_REG;
		endcase
	end

	always_comb begin
		case (wbSel)
			WB_MEM: wrData = memData;
			WB_PC2: wrData = pcPlus2;
			default: wrData = aluOut;
		endcase
	end

	assign wrEn = regWrite && run && !halted;

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
// Fetch unit with instruction memory, PC, branch and jump targets and halt state
`timescale 1ns/100ps
`default_nettype none

module fetchUnit import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic loadEn,
	input wire imemAddr_t loadAddr,
	input wire word_t loadData,
	input wire logic run,
	input wire logic branch,
	input wire brCond_t brCond,
	input wire logic jump,
	input wire logic jumpReg,
	input wire logic halt,
	input wire word_t rsData,
	input wire word_t aluOut,
	output word_t pc,
	output word_t pcPlus2,
	output word_t instr,
	output logic halted
);

	word_t imem [IMEM_WORDS];
	logic brTaken;
	word_t brTarget;
	word_t jTarget;
	word_t nextPc;

	always_ff @(posedge clk) begin
		if (loadEn) begin
			imem[loadAddr] <= loadData;
		end
	end

	// Byte-addressed PC, word-indexed memory
	assign instr = imem[pc[$bits(imemAddr_t):1]];
	assign pcPlus2 = pc + 16'd2;

	always_comb begin
		case (brCond)
			BR_EQZ: brTaken = (rsData == '0);
			BR_NEZ: brTaken = (rsData != '0);
			BR_LTZ: brTaken = rsData[15];
			BR_GEZ: brTaken = !rsData[15];
		endcase
	end

	assign brTarget = pcPlus2 + {{8{instr[7]}}, instr[7:0]};
	assign jTarget = pcPlus2 + {{5{instr[10]}}, instr[10:0]};

	always_comb begin
		if (jumpReg) begin
			nextPc = aluOut;
		end else if (jump) begin
			nextPc = jTarget;
		end else if (branch && brTaken) begin
			nextPc = brTarget;
		end else begin
			nextPc = pcPlus2;
		end
	end

	// PC stays on the halt instruction
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			halted <= 1'b0;
		end else if (run && !halted) begin
			if (halt) begin
				halted <= 1'b1;
			end else begin
				pc <= nextPc;
			end
		end
	end

endmodule

`default_nettype wire

/* design/dataMem.sv */
// Data memory, word-indexed, with combinational read and clocked write
`timescale 1ns/100ps
`default_nettype none

module dataMem import cpuPkg::*; (
	input wire logic clk,
	input wire word_t addr,
	input wire word_t wrData,
	input wire logic memWrite,
	input wire logic memRead,
	input wire logic run,
	input wire logic halted,
	output word_t rdData
);

	word_t mem [DMEM_WORDS];
	dmemAddr_t wordIdx;

	// Byte address to word index
	assign wordIdx = addr[$bits(dmemAddr_t):1];

	always_ff @(posedge clk) begin
		if (memWrite && run && !halted) begin
			mem[wordIdx] <= wrData;
		end
	end

	assign rdData = memRead ? mem[wordIdx] : '0;

endmodule

`default_nettype wire

/* design/cpuCore.sv */
// Single-cycle core top level tying fetch, decode, registers, execute and memory
`timescale 1ns/100ps
`default_nettype none

module cpuCore import cpuPkg::*; (
	input wire logic clk,
	input wire logic rstN,
	input wire logic loadEn,
	input wire imemAddr_t loadAddr,
	input wire word_t loadData,
	input wire logic run,
	output word_t pc,
	output logic wbEn,
	output regIdx_t wbReg,
	output word_t wbData,
	output logic halted
);

	word_t instr;
	word_t pcPlus2;
	word_t rsData;
	word_t rtData;
	word_t memData;
	word_t aluOut;
	word_t storeData;
	regIdx_t rsIdx;
	regIdx_t rtIdx;

	aluOp_t aluOp;
	immSel_t immSel;
	destSel_t destSel;
	wbSel_t wbSel;
	brCond_t brCond;
	logic aluSrc;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic branch;
	logic jump;
	logic jumpReg;
	logic halt;

	fetchUnit fetch (
		.clk(clk),
		.rstN(rstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.run(run),
		.branch(branch),
		.brCond(brCond),
		.jump(jump),
		.jumpReg(jumpReg),
		.halt(halt),
		.rsData(rsData),
		.aluOut(aluOut),
		.pc(pc),
		.pcPlus2(pcPlus2),
		.instr(instr),
		.halted(halted)
	);

	instrDecoder decoder (
		.instr(instr),
		.aluOp(aluOp),
		.immSel(immSel),
		.destSel(destSel),
		.wbSel(wbSel),
		.brCond(brCond),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.branch(branch),
		.jump(jump),
		.jumpReg(jumpReg),
		.halt(halt)
	);

	regFile regs (
		.clk(clk),
		.rstN(rstN),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.wrIdx(wbReg),
		.wrEn(wbEn),
		.wrData(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

	// Register write doubles as the write-back port
	execUnit exec (
		.instr(instr),
		.rsData(rsData),
		.rtData(rtData),
		.memData(memData),
		.pcPlus2(pcPlus2),
		.aluOp(aluOp),
		.immSel(immSel),
		.destSel(destSel),
		.wbSel(wbSel),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.run(run),
		.halted(halted),
		.rsIdx(rsIdx),
		.rtIdx(rtIdx),
		.wrIdx(wbReg),
		.wrEn(wbEn),
		.wrData(wbData),
		.aluOut(aluOut),
		.storeData(storeData)
	);

	dataMem dmem (
		.clk(clk),
		.addr(aluOut),
		.wrData(storeData),
		.memWrite(memWrite),
		.memRead(memRead),
		.run(run),
		.halted(halted),
		.rdData(memData)
	);

endmodule

`default_nettype wire

/* tb/cpuTb.sv */
// Testbench for the single-cycle core that replays a golden program against its write-back trace
`timescale 1ns/100ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

	localparam int CLK_HALF = 20;
	localparam int RESET_CYCLES = 8;
	localparam int WORDS_PER_LINE = 8;
	localparam int HALT_HOLD_CYCLES = 4;

	logic clk;
	logic rstN;
	logic loadEn;
	imemAddr_t loadAddr;
	word_t loadData;
	logic run;
	word_t pc;
	logic wbEn;
	regIdx_t wbReg;
	word_t wbData;
	logic halted;

	word_t progWords[$];
	string expTest[$];
	regIdx_t expReg[$];
	word_t expVal[$];
	bit expLast[$];

	int expIdx = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int testErrStart = 0;
	int testEntries = 0;
	int cycleLimit = 0;

	cpuCore DUT (
		.clk(clk),
		.rstN(rstN),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.run(run),
		.pc(pc),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	task automatic checkValue(input string testName, input string what,
			input word_t expected, input word_t actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("ERROR %s: %s expected %h, actual %h", testName, what, expected, actual);
		end
	endtask

	task automatic finishTest(input string testName);
		int mismatches;
		mismatches = errorCount - testErrStart;
		if (mismatches == 0) begin
			testsPassed++;
			$display("%-8s ok   %0d entries", testName, testEntries);
		end else begin
			testsFailed++;
			$display("%-8s BAD  %0d entries, %0d errors", testName, testEntries, mismatches);
		end
		testErrStart = errorCount;
		testEntries = 0;
	endtask

	task automatic endRun();
		$display("Tests: %0d ok, %0d bad; checks: %0d; errors: %0d",
			testsPassed, testsFailed, checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// Golden records are comments, program words or a test with its trace
	task automatic readGolden(output bit ok);
		int fd;
		int n;
		int count;
		int regNum;
		logic [7:0] tag;
		logic [8*16-1:0] nameBuf;
		logic [8*128-1:0] lineBuf;
		word_t value;
		bit done;
		ok = 1'b1;
		done = 1'b0;
		fd = $fopen("tb/cpuGolden.txt", "r");
		if (fd == 0) begin
			$display("Could not open the golden file tb/cpuGolden.txt");
			ok = 1'b0;
			done = 1'b1;
		end
		while (!done) begin
			n = $fscanf(fd, "%s", tag);
			if (n != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				n = $fgets(lineBuf, fd);
			end else if (tag == "P") begin
				for (int k = 0; k < WORDS_PER_LINE; k++) begin
					n = $fscanf(fd, "%h", value);
					if (n != 1) begin
						ok = 1'b0;
					end
					progWords.push_back(value);
				end
			end else if (tag == "W") begin
				n = $fscanf(fd, "%s %d", nameBuf, count);
				if (n != 2) begin
					ok = 1'b0;
					done = 1'b1;
				end else begin
					for (int k = 0; k < count; k++) begin
						n = $fscanf(fd, "%d %h", regNum, value);
						if (n != 2) begin
							ok = 1'b0;
						end
						expTest.push_back(string'(nameBuf));
						expReg.push_back(regIdx_t'(regNum));
						expVal.push_back(value);
						expLast.push_back(k == count - 1);
					end
				end
			end else begin
				ok = 1'b0;
				done = 1'b1;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
			if (!ok) begin
				$display("The golden file holds a malformed or unknown record");
			end
		end
		if (ok && (progWords.size() == 0 || expReg.size() == 0)) begin
			$display("The golden file holds no program or no expected trace");
			ok = 1'b0;
		end
	endtask

	task automatic loadProgram();
		foreach (progWords[i]) begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= imemAddr_t'(i);
			loadData <= progWords[i];
		end
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	// Byte address of the first halt word in the program
	function automatic word_t findHaltAddr();
		word_t addr;
		addr = '1;
		for (int i = progWords.size() - 1; i >= 0; i--) begin
			if (progWords[i][15:11] == OP_HALT) begin
				addr = word_t'(2 * i);
			end
		end
		return addr;
	endfunction

	// After halt the PC stays on the halt word and halted stays up
	task automatic verifyHalt();
		word_t haltPc;
		haltPc = findHaltAddr();
		testErrStart = errorCount;
		testEntries = 0;
		repeat (HALT_HOLD_CYCLES) begin
			@(negedge clk);
			checkValue("halt", "pc", haltPc, pc);
			checkValue("halt", "halted", 16'd1, word_t'(halted));
			testEntries++;
		end
		finishTest("halt");
	endtask

	// Write-back port is stable mid-cycle
	always @(negedge clk) begin
		if (wbEn === 1'b1) begin
			if (expIdx >= expReg.size()) begin
				errorCount++;
				$display("Unexpected write-back of %h to r%0d after the trace was exhausted",
					wbData, wbReg);
			end else begin
				checkValue(expTest[expIdx], "register", word_t'(expReg[expIdx]),
					word_t'(wbReg));
				checkValue(expTest[expIdx], "data", expVal[expIdx], wbData);
				testEntries++;
				if (expLast[expIdx]) begin
					finishTest(expTest[expIdx]);
				end
				expIdx++;
			end
		end
	end

	initial begin
		wait (cycleLimit > 0);
		repeat (cycleLimit) @(posedge clk);
		$display("Timeout: the core did not halt within %0d cycles", cycleLimit);
		errorCount++;
		endRun();
	end

	initial begin
		bit ok;
		rstN <= 1'b0;
		loadEn <= 1'b0;
		loadAddr <= '0;
		loadData <= '0;
		run <= 1'b0;
		readGolden(ok);
		if (!ok) begin
			errorCount++;
			endRun();
		end else begin
			cycleLimit = progWords.size() + 4 * expReg.size() + 50;
			repeat (RESET_CYCLES) @(posedge clk);
			rstN <= 1'b1;
			loadProgram();
			@(posedge clk);
			run <= 1'b1;
			wait (halted === 1'b1);
			if (expIdx < expReg.size()) begin
				errorCount++;
				$display("The core halted after %0d of %0d expected write-backs",
					expIdx, expReg.size());
			end
			verifyHalt();
			endRun();
		end
	end

endmodule

`default_nettype wire

/* tb/cpuGolden.txt */
# P: eight program words in hex, loaded from instruction address 0 upward
# W: test name, entry count, then register and hex value pairs in write-back order
P C135 415D 4965 539F 59A6 A3C4 A9C3 B1C4
P BBC5 C112 9134 C2F0 920F D94C D94D D94E
P D94F C413 D194 D295 D196 D297 C918 E138
P E958 F138 F958 C340 8324 8B84 9B5E 8BA0
P 6002 C6EE C601 6102 C602 6902 C6EE 6802
P C603 7202 C6EE 7102 C604 7902 C6EE 7A02
P C605 2002 C6EE 3002 C6EE C16C 2904 C6EE
P C274 3A04 C6EE C6EE 0800 C666 0000 C6EE
# lbi, addi, subi, xori, andi, roli, slli, rori, srli
W imm 9
  1 0035 2 0032 3 FFD0 4 FFCF 5 0031 6 FD0F 6 01A8 6 5003 6 07FE
# lbi and slbi setup, add, sub, xor, andn, rol, sll, ror, srl
# then btr, seq, slt, sle, sco
W regalu 18
  1 0012 1 1234 2 FFF0 2 F00F 3 0243 3 DDDB 3 E23B 3 0230 4 0013
  5 91A0 5 8078 5 8246 5 1E01 6 2C48 6 0001 6 0000 6 0001 6 0001
# base setup, st then ld, stu updates its base, ld through the new base
W mem 4
  3 0040 4 1234 3 003E 5 F00F
# each branch taken then not taken, skipped words would write FFEE
W branch 5
  6 0001 6 0002 6 0003 6 0004 6 0005
# j, jal links 0068, jr, jalr links 0074, landing marker
W jump 5
  7 0068 1 006C 2 0074 7 0074 6 0066

/* tb.f */
common/cpuPkg.sv
decode/instrDecoder.sv
design/regFile.sv
design/execUnit.sv
design/fetchUnit.sv
design/dataMem.sv
design/cpuCore.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/sh
# Build the core testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module cpuTb \
	-f tb.f -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
